// File: rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // RV32I major opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam word_t NOP_INST = 32'h0000_0033; // add x0, x0, x0

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM, WB_IMM} wb_sel_e;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_JAL} br_type_e;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

    // Zero value of every struct below is a bubble
    typedef struct packed {
        logic     rs1_used;
        logic     rs2_used;
        logic     rf_we;
        logic     alu_src1_pc;
        logic     alu_src2_imm;
        alu_op_e  alu_op;
        wb_sel_e  wb_sel;
        br_type_e br_type;
        logic     mem_we;
        logic     is_load;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     result;     // ALU, pc+4 or immediate
        word_t     store_data;
        reg_addr_t rd;
        logic      rf_we;
        logic      mem_we;
        logic      is_load;
    } ex_mem_t;

    typedef struct packed {
        word_t     result;
        word_t     load_data;
        reg_addr_t rd;
        logic      rf_we;
        logic      is_load;
    } mem_wb_t;

endpackage

// File: rtl/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Flush wins over stall, all-zero payload is a bubble
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// File: rtl/reg_file.sv
module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  reg_addr_t ra0,
    input  reg_addr_t ra1,
    output word_t     rd0,
    output word_t     rd1,
    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd
);

    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so decode sees the writeback value in the same cycle
    assign rd0 = (ra0 == '0) ? '0 : (we && wa == ra0) ? wd : regs[ra0];
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];

endmodule

// File: rtl/decoder.sv
module decoder import cpu_pkg::*; (
    input  word_t inst,
    output ctrl_t ctrl,
    output word_t imm
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct7 = inst[31:25];
    assign funct3 = inst[14:12];

    always_comb begin
        ctrl = '0;
        imm  = '0;
        // Canonical nop carries no controls at all
        if (inst != NOP_INST) begin
            case (opcode)
                OP_R: begin
                    ctrl.rs1_used = 1'b1;
                    ctrl.rs2_used = 1'b1;
                    ctrl.rf_we    = 1'b1;
                    case ({funct7, funct3})
                        {7'h00, 3'b000}: ctrl.alu_op = ALU_ADD;
                        {7'h20, 3'b000}: ctrl.alu_op = ALU_SUB;
                        {7'h00, 3'b111}: ctrl.alu_op = ALU_AND;
                        {7'h00, 3'b110}: ctrl.alu_op = ALU_OR;
                        {7'h00, 3'b100}: ctrl.alu_op = ALU_XOR;
                        {7'h00, 3'b010}: ctrl.alu_op = ALU_SLT;
                        default:         ctrl = '0;
                    endcase
                end
                OP_I: if (funct3 == 3'b000) begin // addi only
                    ctrl.rs1_used     = 1'b1;
                    ctrl.rf_we        = 1'b1;
                    ctrl.alu_src2_imm = 1'b1;
                    imm = {{20{inst[31]}}, inst[31:20]};
                end
                OP_LUI: begin
                    ctrl.rf_we  = 1'b1;
                    ctrl.wb_sel = WB_IMM;
                    imm = {inst[31:12], 12'b0};
                end
                OP_LOAD: if (funct3 == 3'b010) begin // lw only
                    ctrl.rs1_used     = 1'b1;
                    ctrl.rf_we        = 1'b1;
                    ctrl.alu_src2_imm = 1'b1;
                    ctrl.is_load      = 1'b1;
                    ctrl.wb_sel       = WB_MEM;
                    imm = {{20{inst[31]}}, inst[31:20]};
                end
                OP_STORE: if (funct3 == 3'b010) begin
                    ctrl.rs1_used     = 1'b1;
                    ctrl.rs2_used     = 1'b1;
                    ctrl.alu_src2_imm = 1'b1;
                    ctrl.mem_we       = 1'b1;
                    imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                end
                OP_BRANCH: begin
                    // ALU forms pc + offset, comparator decides
                    ctrl.rs1_used     = 1'b1;
                    ctrl.rs2_used     = 1'b1;
                    ctrl.alu_src1_pc  = 1'b1;
                    ctrl.alu_src2_imm = 1'b1;
                    imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                    case (funct3)
                        3'b000:  ctrl.br_type = BR_EQ;
                        3'b001:  ctrl.br_type = BR_NE;
                        3'b100:  ctrl.br_type = BR_LT;
                        default: ctrl = '0;
                    endcase
                end
                OP_JAL: begin
                    ctrl.rf_we        = 1'b1;
                    ctrl.alu_src1_pc  = 1'b1;
                    ctrl.alu_src2_imm = 1'b1;
                    ctrl.br_type      = BR_JAL;
                    ctrl.wb_sel       = WB_PC4; // Link value
                    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                end
                default: ctrl = '0;
            endcase
        end
    end

endmodule

// File: rtl/execute_unit.sv
module execute_unit import cpu_pkg::*; (
    input  id_ex_t   id_ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  word_t    mem_fwd,
    input  word_t    wb_fwd,
    output ex_mem_t  ex_mem,
    output logic     redirect,
    output word_t    target
);

    word_t op_a;
    word_t op_b;
    word_t src1;
    word_t src2;
    word_t alu_y;
    logic  taken;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a = fwd_mux(fwd_a, id_ex.rs1_val, mem_fwd, wb_fwd);
    assign op_b = fwd_mux(fwd_b, id_ex.rs2_val, mem_fwd, wb_fwd);

    assign src1 = id_ex.ctrl.alu_src1_pc  ? id_ex.pc  : op_a;
    assign src2 = id_ex.ctrl.alu_src2_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_y = src1 - src2;
            ALU_AND: alu_y = src1 & src2;
            ALU_OR:  alu_y = src1 | src2;
            ALU_XOR: alu_y = src1 ^ src2;
            ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            default: alu_y = src1 + src2;
        endcase
    end

    always_comb begin
        case (id_ex.ctrl.br_type)
            BR_EQ:   taken = (op_a == op_b);
            BR_NE:   taken = (op_a != op_b);
            BR_LT:   taken = ($signed(op_a) < $signed(op_b));
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = taken;
    assign target   = alu_y; // pc + imm for branches and jal

    always_comb begin
        ex_mem = '0;
        case (id_ex.ctrl.wb_sel)
            WB_PC4:  ex_mem.result = id_ex.pc + 32'd4;
            WB_IMM:  ex_mem.result = id_ex.imm;
            default: ex_mem.result = alu_y; // Also the address of lw and sw
        endcase
        ex_mem.store_data = op_b;
        ex_mem.rd         = id_ex.rd;
        ex_mem.rf_we      = id_ex.ctrl.rf_we;
        ex_mem.mem_we     = id_ex.ctrl.mem_we;
        ex_mem.is_load    = id_ex.ctrl.is_load;
    end

endmodule

// File: rtl/hazard_unit.sv
module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  ctrl_t     id_ctrl,
    input  id_ex_t    ex_stage,
    input  ex_mem_t   mem_stage,
    input  mem_wb_t   wb_stage,
    input  logic      redirect,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output logic      stall_front,
    output logic      flush_if_id,
    output logic      flush_id_ex
);

    logic load_use;

    // Memory stage has priority, its load data is not ready yet
    function automatic fwd_sel_e pick_fwd(reg_addr_t rs, ex_mem_t m, mem_wb_t w);
        if (m.rf_we && !m.is_load && m.rd != '0 && m.rd == rs) begin
            return FWD_MEM;
        end
        if (w.rf_we && w.rd != '0 && w.rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a = pick_fwd(ex_stage.rs1, mem_stage, wb_stage);
    assign fwd_b = pick_fwd(ex_stage.rs2, mem_stage, wb_stage);

    // Load in execute feeding the instruction in decode
    assign load_use = ex_stage.ctrl.is_load && ex_stage.rd != '0 &&
                      ((id_ctrl.rs1_used && id_rs1 == ex_stage.rd) ||
                       (id_ctrl.rs2_used && id_rs2 == ex_stage.rd));

    assign stall_front = load_use && !redirect; // Redirect wins
    assign flush_if_id = redirect;
    assign flush_id_ex = redirect || load_use;  // Bubble behind the load

endmodule

// File: rtl/cpu.sv
module cpu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    output word_t im_addr,
    input  word_t im_dout,
    output word_t mem_addr,
    output logic  mem_we,
    output word_t mem_din,
    input  word_t mem_dout
);

    word_t     pc;
    if_id_t    if_d;
    if_id_t    if_q;
    id_ex_t    id_d;
    id_ex_t    id_q;
    ex_mem_t   ex_d;
    ex_mem_t   ex_q;
    mem_wb_t   wb_d;
    mem_wb_t   wb_q;
    ctrl_t     id_ctrl;
    word_t     id_imm;
    word_t     rs1_val;
    word_t     rs2_val;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    word_t     wb_data;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    logic      redirect;
    word_t     target;
    logic      stall_front;
    logic      flush_if_id;
    logic      flush_id_ex;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else if (!stall_front) begin
            pc <= pc + 32'd4;
        end
    end

    assign im_addr = pc;
    assign if_d    = '{pc: pc, inst: im_dout};

    stage_reg #(.payload_t(if_id_t)) i_if_id (
        .clk(clk), .reset(reset), .stall(stall_front), .flush(flush_if_id), .d(if_d), .q(if_q)
    );

    assign id_rs1 = if_q.inst[19:15];
    assign id_rs2 = if_q.inst[24:20];

    reg_file i_reg_file (
        .clk(clk), .ra0(id_rs1), .ra1(id_rs2), .rd0(rs1_val), .rd1(rs2_val),
        .we(wb_q.rf_we), .wa(wb_q.rd), .wd(wb_data)
    );

    decoder i_decoder (.inst(if_q.inst), .ctrl(id_ctrl), .imm(id_imm));

    assign id_d = '{pc: if_q.pc, rs1: id_rs1, rs2: id_rs2, rd: if_q.inst[11:7],
                    rs1_val: rs1_val, rs2_val: rs2_val, imm: id_imm, ctrl: id_ctrl};

    stage_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(flush_id_ex), .d(id_d), .q(id_q)
    );

    execute_unit i_execute_unit (
        .id_ex(id_q), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_fwd(ex_q.result), .wb_fwd(wb_data),
        .ex_mem(ex_d), .redirect(redirect), .target(target)
    );

    stage_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(ex_d), .q(ex_q)
    );

    assign mem_addr = ex_q.result;
    assign mem_we   = ex_q.mem_we;
    assign mem_din  = ex_q.store_data;
    assign wb_d     = '{result: ex_q.result, load_data: mem_dout, rd: ex_q.rd,
                        rf_we: ex_q.rf_we, is_load: ex_q.is_load};

    stage_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(wb_d), .q(wb_q)
    );

    assign wb_data = wb_q.is_load ? wb_q.load_data : wb_q.result; // Writeback select

    hazard_unit i_hazard_unit (
        .id_rs1(id_rs1), .id_rs2(id_rs2), .id_ctrl(id_ctrl),
        .ex_stage(id_q), .mem_stage(ex_q), .wb_stage(wb_q), .redirect(redirect),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .stall_front(stall_front),
        .flush_if_id(flush_if_id), .flush_id_ex(flush_id_ex)
    );

endmodule

// File: verification/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // Period 20
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: verification/cpu_sva.sv
module cpu_sva import cpu_pkg::*; (
    input logic  clk,
    input logic  reset,
    input word_t im_addr,
    input logic  mem_we
);

    int fail_count = 0;

    // First cycle out of reset holds only bubbles
    a_no_store_after_reset: assert property (@(posedge clk) $fell(reset) |-> !mem_we)
        else begin
            fail_count++;
            $error("mem_we high in the first cycle after reset");
        end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (reset) im_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("im_addr not word aligned: %h", im_addr);
        end

    a_first_fetch_zero: assert property (@(posedge clk) $fell(reset) |-> im_addr == '0)
        else begin
            fail_count++;
            $error("first fetch after reset not at address 0: %h", im_addr);
        end

endmodule

// File: verification/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

    localparam int N_TESTS     = 5;
    localparam int MAX_WORDS   = 12;
    localparam int MAX_STORES  = 3;
    localparam int PROG_CYCLES = 40;
    localparam int CYCLE_LIMIT = N_TESTS * 50;

    logic  clk;
    logic  por_reset;
    logic  prog_reset;
    logic  reset;
    logic  dmem_clear;
    word_t im_addr;
    word_t im_dout;
    word_t mem_addr;
    logic  mem_we;
    word_t mem_din;
    word_t mem_dout;
    int    cycle_count = 0;
    int    checks;
    int    errors;

    word_t imem [64] = '{default: '0};
    word_t dmem [64] = '{default: '0};

    string test_name [N_TESTS] = '{"arith_fwd", "load_use", "beq_taken", "signed_branch",
                                   "jal_lui_x0"};

    word_t prog [N_TESTS][MAX_WORDS] = '{
        // addi x1,5  addi x2,12  add x3  sub x4  xor x5  and x6  or x7  sw x7,x6,x3  jal
        '{32'h00500093, 32'h00C00113, 32'h002081B3, 32'h40118233, 32'h003242B3, 32'h0042F333,
          32'h005363B3, 32'h04702023, 32'h04602223, 32'h04302423, 32'h0000006F, 32'h0},
        // addi x1,100  sw x1  lw x2  add x3,x2,x1  sw x3  jal
        '{32'h06400093, 32'h04102023, 32'h04002103, 32'h001101B3, 32'h04302223, 32'h0000006F,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        // Two poison words after the beq
        '{32'h00700093, 32'h00700113, 32'h00208663, 32'h06300113, 32'h04202223, 32'h04202023,
          32'h00100193, 32'h04302223, 32'h0000006F, 32'h0, 32'h0, 32'h0},
        // x1 = -3, slt, bne not taken, blt taken over a poison store
        '{32'hFFD00093, 32'h00200113, 32'h0020A1B3, 32'h00100213, 32'h00419463, 32'h04302023,
          32'h0020C463, 32'h04102223, 32'h04202223, 32'h0000006F, 32'h0, 32'h0},
        // jal x1,+8 over sw x0; lui x5; addi x0,55 then store x0
        '{32'h008000EF, 32'h04002023, 32'h04102023, 32'h123452B7, 32'h04502223, 32'h03700013,
          32'h04002423, 32'h0000006F, 32'h0, 32'h0, 32'h0, 32'h0}
    };

    int    n_stores [N_TESTS] = '{3, 2, 2, 2, 3};
    word_t st_addr [N_TESTS][MAX_STORES] = '{
        '{32'h40, 32'h44, 32'h48}, '{32'h40, 32'h44, 32'h0}, '{32'h40, 32'h44, 32'h0},
        '{32'h40, 32'h44, 32'h0}, '{32'h40, 32'h44, 32'h48}
    };
    word_t st_data [N_TESTS][MAX_STORES] = '{
        '{32'h1D, 32'h0C, 32'h11}, '{32'h64, 32'hC8, 32'h0}, '{32'h07, 32'h01, 32'h0},
        '{32'h01, 32'h02, 32'h0}, '{32'h04, 32'h12345000, 32'h0}
    };

    clk_gen i_clk_gen (.clk(clk), .reset(por_reset));

    assign reset = por_reset || prog_reset;

    cpu i_cpu (
        .clk(clk), .reset(reset), .im_addr(im_addr), .im_dout(im_dout),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_din(mem_din), .mem_dout(mem_dout)
    );

    bind cpu cpu_sva i_cpu_sva (.clk(clk), .reset(reset), .im_addr(im_addr), .mem_we(mem_we));

    assign im_dout  = imem[im_addr[7:2]];
    assign mem_dout = dmem[mem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_clear) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_we) begin
            dmem[mem_addr[7:2]] <= mem_din;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic compare(input string test, input string what, input word_t expected,
                           input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: %s expected %h, got %h", test, what, expected, actual);
        end
    endtask

    initial begin
        int seen;
        int cyc;
        checks     = 0;
        errors     = 0;
        prog_reset = 1'b0;
        dmem_clear = 1'b0;
        for (int t = 0; t < N_TESTS; t++) begin
            @(posedge clk);
            prog_reset <= 1'b1;
            dmem_clear <= 1'b1;
            for (int w = 0; w < 64; w++) begin
                if (w < MAX_WORDS) begin
                    imem[w] <= prog[t][w];
                end else begin
                    imem[w] <= '0;
                end
            end
            @(posedge clk);
            dmem_clear <= 1'b0;
            @(posedge clk);
            prog_reset <= 1'b0; // Two reset cycles seen by the DUT
            seen = 0;
            cyc  = 0;
            while (seen < n_stores[t] && cyc < PROG_CYCLES) begin
                @(posedge clk);
                cyc++;
                if (cyc == 1) begin
                    compare(test_name[t], "first fetch address", '0, im_addr);
                end
                if (mem_we) begin
                    compare(test_name[t], "store address", st_addr[t][seen], mem_addr);
                    compare(test_name[t], "store data", st_data[t][seen], mem_din);
                    seen++;
                end
            end
            if (seen < n_stores[t]) begin
                errors++;
                $display("Test %s saw only %0d of %0d stores within %0d cycles",
                         test_name[t], seen, n_stores[t], PROG_CYCLES);
            end
        end
        errors += i_cpu.i_cpu_sva.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/cpu_pkg.sv
rtl/stage_reg.sv
rtl/reg_file.sv
rtl/decoder.sv
rtl/execute_unit.sv
rtl/hazard_unit.sv
rtl/cpu.sv
verification/clk_gen.sv
verification/cpu_sva.sv
verification/cpu_tb.sv

// File: Makefile
TOP := cpu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
